/* vlog.f */
+incdir+hw
hw/jtag_dbg_pkg.sv
hw/jtag_tap_ctrl.sv
hw/jtag_shift_reg.sv
hw/dbg_mem_bridge.sv
hw/jtag_dbg_top.sv
dv/jtag_dbg_properties.sv
dv/jtag_dbg_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the JTAG debug port testbench with Verilator.
# Exits non-zero unless the log reports a pass.

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module jtag_dbg_tb \
  -Mdir obj_dir -o jtag_dbg_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/jtag_dbg_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* dv/jtag_dbg_tests.txt */
# name kind addr(hex) data(hex or rand) expected(hex)
# kinds: idcode/tmsreset/trst expect a word, write/read a status, bypass an IR code
idcode_after_reset idcode 00 0 11d4b54b
wr_a00 write 00 rand 0
wr_a05 write 05 deadbeef 0
wr_a3f write 3f rand 0
wr_a21 write 21 rand 0
rd_a00 read 00 0 0
rd_a05 read 05 0 0
rd_a3f read 3f 0 0
wr_oob_40 write 40 12345678 2
rd_oob_80 read 80 0 2
rd_a05_after_oob read 05 0 0
wr_a00_again write 00 rand 0
rd_a00_again read 00 0 0
bypass_std bypass 1f rand 0
bypass_code_05 bypass 05 rand 0
bypass_code_0a bypass 0a rand 0
tms_reset tmsreset 00 0 11d4b54b
rd_a05_after_tms read 05 0 0
trst_reset trst 00 0 11d4b54b
rd_a3f_after_trst read 3f 0 0
wr_oob_ff write ff rand 2
rd_a21_final read 21 0 0
rd_a00_final read 00 0 0

/* dv/jtag_dbg_tb.sv */
/*
 * Testbench for the JTAG debug port. Bit-bangs TCK through the pins and
 * runs the tests listed in dv/jtag_dbg_tests.txt against a memory model.
 */

`default_nettype none

`include "jtag_dbg_defs.svh"

module jtag_dbg_tb;

  logic clk_i = 1'b0;
  logic rst_n_i, jtag_tck_i, jtag_trst_ni, jtag_tms_i, jtag_tdi_i;
  wire logic jtag_tdo_o, jtag_tdo_oe_o;

  int errors = 0;
  int checks = 0;
  bit tests_loaded = 1'b0;
  string cur_name = "init";

  string       t_name[$];
  string       t_kind[$];
  logic [7:0]  t_addr[$];
  logic [31:0] t_data[$];
  logic [31:0] t_exp[$];
  logic [31:0] model[`DBG_MEM_DEPTH];

  jtag_dbg_top jtag_dbg_top_inst (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .jtag_tck_i    ( jtag_tck_i    ),
    .jtag_trst_ni  ( jtag_trst_ni  ),
    .jtag_tms_i    ( jtag_tms_i    ),
    .jtag_tdi_i    ( jtag_tdi_i    ),
    .jtag_tdo_o    ( jtag_tdo_o    ),
    .jtag_tdo_oe_o ( jtag_tdo_oe_o )
  );

  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////////
  // JTAG bit-bang, 8 clocks per TCK period
  //////////////////////////////////////////////////////////////////////////

  // Entered at posedge+1 with TCK high; TDO sampled just before the rise
  task automatic tck_pulse(input logic tms, input logic tdi, input logic exp_oe,
                           output logic tdo);
    jtag_tck_i = 1'b0;
    jtag_tms_i = tms;
    jtag_tdi_i = tdi;
    repeat (4) @(posedge clk_i);
    #1;
    tdo = jtag_tdo_o;
    checks++;
    if (jtag_tdo_oe_o !== exp_oe) begin
      errors++;
      $display("TDO enable was %b instead of %b before a TCK rise in %s",
               jtag_tdo_oe_o, exp_oe, cur_name);
    end
    jtag_tck_i = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
  endtask

  // From Run-Test-Idle back to Run-Test-Idle
  task automatic dr_scan(input int n, input logic [63:0] din, output logic [63:0] dout);
    logic b;
    dout = '0;
    tck_pulse(1'b1, 1'b0, 1'b0, b);
    tck_pulse(1'b0, 1'b0, 1'b0, b);
    tck_pulse(1'b0, 1'b0, 1'b0, b);
    for (int i = 0; i < n; i++) begin
      tck_pulse(i == n - 1, din[i], 1'b1, b);
      dout[i] = b;
    end
    tck_pulse(1'b1, 1'b0, 1'b0, b);
    tck_pulse(1'b0, 1'b0, 1'b0, b);
  endtask

  task automatic ir_scan(input logic [`JTAG_IR_LEN-1:0] code);
    logic b;
    tck_pulse(1'b1, 1'b0, 1'b0, b);
    tck_pulse(1'b1, 1'b0, 1'b0, b);
    tck_pulse(1'b0, 1'b0, 1'b0, b);
    tck_pulse(1'b0, 1'b0, 1'b0, b);
    for (int i = 0; i < `JTAG_IR_LEN; i++) begin
      tck_pulse(i == `JTAG_IR_LEN - 1, code[i], 1'b1, b);
    end
    tck_pulse(1'b1, 1'b0, 1'b0, b);
    tck_pulse(1'b0, 1'b0, 1'b0, b);
  endtask

  task automatic tms_reset();
    logic b;
    repeat (5) tck_pulse(1'b1, 1'b0, 1'b0, b);
    tck_pulse(1'b0, 1'b0, 1'b0, b);
  endtask

  task automatic trst_pulse();
    logic b;
    jtag_trst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    jtag_trst_ni = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    tck_pulse(1'b0, 1'b0, 1'b0, b);
  endtask

  // Request scan, then a nop scan that shifts out the result
  task automatic dmi_access(input logic [1:0] op, input logic [7:0] addr,
                            input logic [31:0] data, output logic [41:0] result);
    logic [63:0] dout;
    ir_scan(`IR_DMIACCESS);
    dr_scan(42, {22'd0, op, addr, data}, dout);
    dr_scan(42, 64'd0, dout);
    result = dout[41:0];
  endtask

  task automatic load_tests();
    int    fd;
    string line, nm, kd, ds;
    logic [7:0]  ad;
    logic [31:0] dv, ex;
    fd = $fopen("dv/jtag_dbg_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the test file dv/jtag_dbg_tests.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) != "#") begin
        if ($sscanf(line, "%s %s %h %s %h", nm, kd, ad, ds, ex) == 5) begin
          if (ds == "rand") begin
            dv = $urandom;
          end else begin
            void'($sscanf(ds, "%h", dv));
          end
          t_name.push_back(nm);
          t_kind.push_back(kd);
          t_addr.push_back(ad);
          t_data.push_back(dv);
          t_exp.push_back(ex);
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    logic [63:0] dout;
    logic [41:0] res;
    logic [31:0] exp_word;
    logic [7:0]  alias_addr;
    int unsigned seed_val;
    seed_val = $urandom(32'hffaf);
    rst_n_i = 1'b0;
    jtag_tck_i = 1'b1;
    jtag_trst_ni = 1'b1;
    jtag_tms_i = 1'b1;
    jtag_tdi_i = 1'b0;
    load_tests();
    if (t_name.size() == 0 && errors == 0) begin
      errors++;
      $display("The test file holds no tests");
    end
    tests_loaded = (t_name.size() > 0);
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    tck_pulse(1'b0, 1'b0, 1'b0, dout[0]);
    foreach (t_name[i]) begin
      cur_name = t_name[i];
      if (t_kind[i] == "idcode" || t_kind[i] == "tmsreset" || t_kind[i] == "trst") begin
        if (t_kind[i] == "tmsreset") tms_reset();
        if (t_kind[i] == "trst") trst_pulse();
        dr_scan(32, 64'd0, dout);
        checks++;
        if (dout[31:0] !== t_exp[i]) begin
          errors++;
          $display("Error %s: expected %h, actual %h", cur_name, t_exp[i], dout[31:0]);
        end
      end else if (t_kind[i] == "write" || t_kind[i] == "read") begin
        dmi_access((t_kind[i] == "write") ? 2'd2 : 2'd1, t_addr[i], t_data[i], res);
        if (t_kind[i] == "write" && t_addr[i] < `DBG_MEM_DEPTH) begin
          model[t_addr[i]] = t_data[i];
        end
        checks++;
        if (res[41:40] !== t_exp[i][1:0] || res[39:32] !== t_addr[i]) begin
          errors++;
          $display("Error %s: expected status %h addr %h, actual status %h addr %h",
                   cur_name, t_exp[i][1:0], t_addr[i], res[41:40], res[39:32]);
        end
        if (t_kind[i] == "read" && t_exp[i][1:0] == `DMI_OK) begin
          checks++;
          if (res[31:0] !== model[t_addr[i]]) begin
            errors++;
            $display("Error %s: expected %h, actual %h", cur_name,
                     model[t_addr[i]], res[31:0]);
          end
        end
        // Out-of-range access must leave the word it wraps onto alone
        if (t_addr[i] >= `DBG_MEM_DEPTH) begin
          alias_addr = 8'(t_addr[i] % `DBG_MEM_DEPTH);
          if (!$isunknown(model[alias_addr])) begin
            dmi_access(2'd1, alias_addr, 32'd0, res);
            checks++;
            if (res[31:0] !== model[alias_addr]) begin
              errors++;
              $display("Error %s: expected %h at address %h, actual %h", cur_name,
                       model[alias_addr], alias_addr, res[31:0]);
            end
          end
        end
      end else if (t_kind[i] == "bypass") begin
        ir_scan(t_addr[i][`JTAG_IR_LEN-1:0]);
        dr_scan(32, {32'd0, t_data[i]}, dout);
        // One-bit delay, first bit out is the captured zero
        exp_word = {t_data[i][30:0], 1'b0};
        checks++;
        if (dout[31:0] !== exp_word) begin
          errors++;
          $display("Error %s: expected %h, actual %h", cur_name, exp_word, dout[31:0]);
        end
      end else begin
        errors++;
        $display("Test %s has an unknown kind %s", cur_name, t_kind[i]);
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // 400 TCK periods of 80 time units per test
  initial begin
    wait (tests_loaded);
    #(64'(t_name.size()) * 400 * 80);
    $display("Watchdog expired before the tests finished, in %s", cur_name);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/jtag_dbg_properties.sv */
/*
 * Assertions on the TAP controller, bound into jtag_tap_ctrl.
 */

`default_nettype none

module jtag_dbg_properties
  import jtag_dbg_pkg::*;
(
  input wire logic        clk_i,
  input wire logic        rst_n_i,
  input wire tap_state_t  state_i,
  input wire logic        tck_rise_i,
  input wire logic        tms_i,
  input wire logic        tdo_oe_i,
  input wire tap_strobe_t ir_strobe_i,
  input wire tap_strobe_t dr_strobe_i
);

  logic [2:0] tms_high_q;

  // Consecutive TCK rises with TMS high, saturating at five
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tms_high_q <= '0;
    end else if (tck_rise_i) begin
      tms_high_q <= !tms_i ? 3'd0 : (tms_high_q == 3'd5) ? 3'd5 : tms_high_q + 3'd1;
    end
  end

  // oe is updated on the fall, so it lingers into Exit1 until then
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tdo_oe_i |-> state_i inside {shift_ir, shift_dr, exit1_ir, exit1_dr})
    else $error("TDO enabled outside a shift state");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !((ir_strobe_i.capture || ir_strobe_i.shift || ir_strobe_i.update) &&
      (dr_strobe_i.capture || dr_strobe_i.shift || dr_strobe_i.update)))
    else $error("IR and DR strobes active together");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ir_strobe_i.update || dr_strobe_i.update) |=>
      !(ir_strobe_i.update || dr_strobe_i.update))
    else $error("Update strobe longer than one cycle");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (tms_high_q == 3'd5) |-> state_i == test_logic_reset)
    else $error("Five TMS-high rises did not reach Test-Logic-Reset");

endmodule

bind jtag_tap_ctrl jtag_dbg_properties jtag_dbg_properties_inst (
  .clk_i       ( clk_i         ),
  .rst_n_i     ( rst_n_i       ),
  .state_i     ( state_q       ),
  .tck_rise_i  ( tck_rise      ),
  .tms_i       ( tms_s         ),
  .tdo_oe_i    ( jtag_tdo_oe_o ),
  .ir_strobe_i ( ir_strobe_o   ),
  .dr_strobe_i ( dr_strobe_o   )
);

`default_nettype wire

/* hw/jtag_dbg_top.sv */
/*
 * Top level of the JTAG debug port. Ties the JTAG pins to the TAP
 * controller, the IR, IDCODE and DMI chains and the debug memory bridge.
 * All logic runs on clk_i; TCK is sampled as an ordinary input.
 */

`default_nettype none

`include "jtag_dbg_defs.svh"

module jtag_dbg_top
  import jtag_dbg_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic jtag_tck_i,
  input  logic jtag_trst_ni,
  input  logic jtag_tms_i,
  input  logic jtag_tdi_i,
  output logic jtag_tdo_o,
  output logic jtag_tdo_oe_o
);

  tap_strobe_t ir_strobe, dr_strobe;
  logic        sel_idcode, sel_dmi;
  logic        ir_so, idcode_so, dmi_so;
  ir_t         ir_word;
  dmi_req_t    dmi_req, dmi_capture;
  logic        dmi_req_valid;

  ////////////////////////////////////////////////////////////////////////////
  // TAP controller
  ////////////////////////////////////////////////////////////////////////////

  jtag_tap_ctrl jtag_tap_ctrl_inst (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .jtag_tck_i    ( jtag_tck_i    ),
    .jtag_trst_ni  ( jtag_trst_ni  ),
    .jtag_tms_i    ( jtag_tms_i    ),
    .jtag_tdi_i    ( jtag_tdi_i    ),
    .ir_so_i       ( ir_so         ),
    .idcode_so_i   ( idcode_so     ),
    .dmi_so_i      ( dmi_so        ),
    .ir_i          ( ir_word       ),
    .ir_strobe_o   ( ir_strobe     ),
    .dr_strobe_o   ( dr_strobe     ),
    .sel_idcode_o  ( sel_idcode    ),
    .sel_dmi_o     ( sel_dmi       ),
    .jtag_tdo_o    ( jtag_tdo_o    ),
    .jtag_tdo_oe_o ( jtag_tdo_oe_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Shift chains
  ////////////////////////////////////////////////////////////////////////////

  jtag_shift_reg #(
    .payload_t  ( ir_t                ),
    .ResetValue ( ir_t'(`IR_IDCODE)   )
  ) ir_reg_inst (
    .clk_i          ( clk_i                  ),
    .rst_n_i        ( rst_n_i                ),
    .sel_i          ( 1'b1                   ),
    .strobe_i       ( ir_strobe              ),
    .capture_i      ( ir_t'(`JTAG_IR_CAPTURE) ),
    .so_o           ( ir_so                  ),
    .update_o       ( ir_word                ),
    .update_valid_o (                        )
  );

  jtag_shift_reg #(
    .payload_t ( idcode_t )
  ) idcode_reg_inst (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .sel_i          ( sel_idcode   ),
    .strobe_i       ( dr_strobe    ),
    .capture_i      ( `JTAG_IDCODE ),
    .so_o           ( idcode_so    ),
    .update_o       (              ),
    .update_valid_o (              )
  );

  jtag_shift_reg #(
    .payload_t ( dmi_req_t )
  ) dmi_reg_inst (
    .clk_i          ( clk_i         ),
    .rst_n_i        ( rst_n_i       ),
    .sel_i          ( sel_dmi       ),
    .strobe_i       ( dr_strobe     ),
    .capture_i      ( dmi_capture   ),
    .so_o           ( dmi_so        ),
    .update_o       ( dmi_req       ),
    .update_valid_o ( dmi_req_valid )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Debug memory
  ////////////////////////////////////////////////////////////////////////////

  dbg_mem_bridge dbg_mem_bridge_inst (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .req_i       ( dmi_req       ),
    .req_valid_i ( dmi_req_valid ),
    .capture_o   ( dmi_capture   )
  );

endmodule

`default_nettype wire

/* hw/dbg_mem_bridge.sv */
/*
 * DMI bridge to the 64-word debug memory. Each request from the DMI chain
 * is carried out in one cycle; the result waits in the capture word until
 * the next DR scan shifts it out.
 */

`default_nettype none

`include "jtag_dbg_defs.svh"

module dbg_mem_bridge
  import jtag_dbg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  dmi_req_t req_i,
  input  logic     req_valid_i,
  output dmi_req_t capture_o
);

  localparam int IdxW = $clog2(`DBG_MEM_DEPTH);

  logic [31:0]            mem_q [`DBG_MEM_DEPTH];
  logic [IdxW-1:0]        idx;
  logic                   in_range;
  logic                   do_read, do_write;
  logic [1:0]             status_q;
  logic [`DMI_ADDR_W-1:0] addr_q;
  logic [31:0]            rdata_q;

  assign idx      = req_i.addr[IdxW-1:0];
  assign in_range = req_i.addr < `DBG_MEM_DEPTH;
  assign do_read  = req_valid_i && (req_i.op == dmi_read);
  assign do_write = req_valid_i && (req_i.op == dmi_write);

  // Storage, kept across resets
  always_ff @(posedge clk_i) begin
    if (do_write && in_range) begin
      mem_q[idx] <= req_i.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result of the last request
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      status_q <= `DMI_OK;
      addr_q   <= '0;
      rdata_q  <= '0;
    end else if (do_read || do_write) begin
      addr_q <= req_i.addr;
      if (!in_range) begin
        status_q <= `DMI_ERR;
      end else begin
        status_q <= `DMI_OK;
        if (do_read) begin
          rdata_q <= mem_q[idx];
        end
      end
    end
  end

  // Nop and unknown ops leave the result alone
  assign capture_o = '{op:   dmi_op_e'(status_q),
                       addr: addr_q,
                       data: rdata_q};

endmodule

`default_nettype wire

/* hw/jtag_shift_reg.sv */
/*
 * One JTAG register: a shift stage fed from TDI at the MSB and an update
 * stage that holds the last scanned word. The payload type is chosen per
 * instance (instruction, IDCODE word or DMI request).
 */

`default_nettype none

module jtag_shift_reg
  import jtag_dbg_pkg::*;
#(
  parameter type      payload_t  = logic [31:0],
  parameter payload_t ResetValue = payload_t'(0)
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        sel_i,
  input  tap_strobe_t strobe_i,
  input  payload_t    capture_i,
  output logic        so_o,
  output payload_t    update_o,
  output logic        update_valid_o
);

  localparam int Width = $bits(payload_t);

  logic [Width-1:0] shift_q;

  // Shift stage
  always_ff @(posedge clk_i) begin
    if (sel_i && strobe_i.capture) begin
      shift_q <= capture_i;
    end else if (sel_i && strobe_i.shift) begin
      shift_q <= {strobe_i.tdi, shift_q[Width-1:1]};
    end
  end

  assign so_o = shift_q[0];

  // Update stage, with a one-cycle valid pulse
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      update_o       <= ResetValue;
      update_valid_o <= 1'b0;
    end else begin
      update_valid_o <= sel_i & strobe_i.update;
      if (sel_i && strobe_i.update) begin
        update_o <= payload_t'(shift_q);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/jtag_tap_ctrl.sv */
/*
 * TAP controller. Oversamples the JTAG pins on clk_i, steps the 1149.1
 * state machine and emits single-cycle strobes to the shift chains.
 * Also decodes the instruction, holds the bypass bit and drives TDO.
 */

`default_nettype none

`include "jtag_dbg_defs.svh"

module jtag_tap_ctrl
  import jtag_dbg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        jtag_tck_i,
  input  logic        jtag_trst_ni,
  input  logic        jtag_tms_i,
  input  logic        jtag_tdi_i,
  input  logic        ir_so_i,
  input  logic        idcode_so_i,
  input  logic        dmi_so_i,
  input  ir_t         ir_i,
  output tap_strobe_t ir_strobe_o,
  output tap_strobe_t dr_strobe_o,
  output logic        sel_idcode_o,
  output logic        sel_dmi_o,
  output logic        jtag_tdo_o,
  output logic        jtag_tdo_oe_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Pin synchronizers and TCK edges
  ////////////////////////////////////////////////////////////////////////////

  logic [3:0] pins_m, pins_s;
  logic       tck_d;
  logic       tck_s, trst_n_s, tms_s, tdi_s;
  logic       tck_rise, tck_fall;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pins_m <= '0;
      pins_s <= '0;
      tck_d  <= 1'b0;
    end else begin
      pins_m <= {jtag_tck_i, jtag_trst_ni, jtag_tms_i, jtag_tdi_i};
      pins_s <= pins_m;
      tck_d  <= tck_s;
    end
  end

  assign {tck_s, trst_n_s, tms_s, tdi_s} = pins_s;
  assign tck_rise = tck_s & ~tck_d;
  assign tck_fall = ~tck_s & tck_d;

  ////////////////////////////////////////////////////////////////////////////
  // TAP state machine
  ////////////////////////////////////////////////////////////////////////////

  tap_state_t state_q, state_d;

  always_comb begin
    unique case (state_q)
      test_logic_reset: state_d = tms_s ? test_logic_reset : run_test_idle;
      run_test_idle:    state_d = tms_s ? select_dr : run_test_idle;
      select_dr:        state_d = tms_s ? select_ir : capture_dr;
      capture_dr:       state_d = tms_s ? exit1_dr : shift_dr;
      shift_dr:         state_d = tms_s ? exit1_dr : shift_dr;
      exit1_dr:         state_d = tms_s ? update_dr : pause_dr;
      pause_dr:         state_d = tms_s ? exit2_dr : pause_dr;
      exit2_dr:         state_d = tms_s ? update_dr : shift_dr;
      update_dr:        state_d = tms_s ? select_dr : run_test_idle;
      select_ir:        state_d = tms_s ? test_logic_reset : capture_ir;
      capture_ir:       state_d = tms_s ? exit1_ir : shift_ir;
      shift_ir:         state_d = tms_s ? exit1_ir : shift_ir;
      exit1_ir:         state_d = tms_s ? update_ir : pause_ir;
      pause_ir:         state_d = tms_s ? exit2_ir : pause_ir;
      exit2_ir:         state_d = tms_s ? update_ir : shift_ir;
      update_ir:        state_d = tms_s ? select_dr : run_test_idle;
      default:          state_d = test_logic_reset;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= test_logic_reset;
    end else if (!trst_n_s) begin
      state_q <= test_logic_reset;
    end else if (tck_rise) begin
      state_q <= state_d;
    end
  end

  // Capture and shift on the TCK rise, update on the fall
  assign ir_strobe_o = '{capture: tck_rise & (state_q == capture_ir),
                         shift:   tck_rise & (state_q == shift_ir),
                         update:  tck_fall & (state_q == update_ir),
                         tdi:     tdi_s};
  assign dr_strobe_o = '{capture: tck_rise & (state_q == capture_dr),
                         shift:   tck_rise & (state_q == shift_dr),
                         update:  tck_fall & (state_q == update_dr),
                         tdi:     tdi_s};

  ////////////////////////////////////////////////////////////////////////////
  // Instruction decode and bypass
  ////////////////////////////////////////////////////////////////////////////

  // Test-Logic-Reset forces IDCODE until the next IR update
  logic ir_reset_q;
  ir_t  instr;
  logic sel_bypass;
  logic bypass_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ir_reset_q <= 1'b1;
    end else if (state_q == test_logic_reset) begin
      ir_reset_q <= 1'b1;
    end else if (ir_strobe_o.update) begin
      ir_reset_q <= 1'b0;
    end
  end

  assign instr = ir_reset_q ? ir_t'(`IR_IDCODE) : ir_i;

  always_comb begin
    sel_idcode_o = 1'b0;
    sel_dmi_o    = 1'b0;
    sel_bypass   = 1'b0;
    case (instr)
      `IR_IDCODE:    sel_idcode_o = 1'b1;
      `IR_DMIACCESS: sel_dmi_o    = 1'b1;
      `IR_BYPASS:    sel_bypass   = 1'b1;
      default:       sel_bypass   = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bypass_q <= 1'b0;
    end else if (sel_bypass && dr_strobe_o.capture) begin
      bypass_q <= 1'b0;
    end else if (sel_bypass && dr_strobe_o.shift) begin
      bypass_q <= tdi_s;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // TDO on the TCK fall
  ////////////////////////////////////////////////////////////////////////////

  logic ir_path;
  logic tdo_d;

  assign ir_path = state_q inside {capture_ir, shift_ir, exit1_ir, pause_ir,
                                   exit2_ir, update_ir};

  always_comb begin
    if (ir_path) begin
      tdo_d = ir_so_i;
    end else if (sel_idcode_o) begin
      tdo_d = idcode_so_i;
    end else if (sel_dmi_o) begin
      tdo_d = dmi_so_i;
    end else begin
      tdo_d = bypass_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      jtag_tdo_o    <= 1'b0;
      jtag_tdo_oe_o <= 1'b0;
    end else if (tck_fall) begin
      jtag_tdo_o    <= tdo_d;
      jtag_tdo_oe_o <= (state_q == shift_ir) || (state_q == shift_dr);
    end
  end

endmodule

`default_nettype wire

/* hw/jtag_dbg_pkg.sv */
/*
 * Types shared by the JTAG debug port: TAP states, instruction field,
 * DMI request and capture word, and the strobe bundle of the TAP.
 */

`default_nettype none

`include "jtag_dbg_defs.svh"

package jtag_dbg_pkg;

  typedef enum logic [3:0] {
    test_logic_reset,
    run_test_idle,
    select_dr,
    capture_dr,
    shift_dr,
    exit1_dr,
    pause_dr,
    exit2_dr,
    update_dr,
    select_ir,
    capture_ir,
    shift_ir,
    exit1_ir,
    pause_ir,
    exit2_ir,
    update_ir
  } tap_state_t;

  typedef logic [`JTAG_IR_LEN-1:0] ir_t;

  typedef logic [31:0] idcode_t;

  typedef enum logic [1:0] {
    dmi_nop   = 2'd0,
    dmi_read  = 2'd1,
    dmi_write = 2'd2
  } dmi_op_e;

  // Also the capture word, with the status in the op field
  typedef struct packed {
    dmi_op_e                op;
    logic [`DMI_ADDR_W-1:0] addr;
    logic [31:0]            data;
  } dmi_req_t;

  typedef struct packed {
    logic capture;
    logic shift;
    logic update;
    logic tdi;
  } tap_strobe_t;

endpackage

`default_nettype wire

/* hw/jtag_dbg_defs.svh */
/*
 * Constants of the JTAG debug port: identification value, instruction
 * codes, debug memory size and DMI status codes. Include where needed.
 */

`ifndef JTAG_DBG_DEFS_SVH
`define JTAG_DBG_DEFS_SVH

// Version 1, part 0x1d4b, manufacturer 0x2a5, LSB fixed at one
`define JTAG_IDCODE 32'h11d4_b54b

`define JTAG_IR_LEN 5

// Low IR bits read back as 01 during Capture-IR
`define JTAG_IR_CAPTURE 5'b00001

`define IR_IDCODE    5'd1
`define IR_DMIACCESS 5'd17
`define IR_BYPASS    5'd31

`define DBG_MEM_DEPTH 64
`define DMI_ADDR_W    8

`define DMI_OK  2'd0
`define DMI_ERR 2'd2

`endif
